/* gpu_mem_pkg.sv */
package gpu_mem_pkg;

	//////////////////////////////////////////////////////////////////////
	// Datapath widths
	//////////////////////////////////////////////////////////////////////

	localparam int LANES = 8;                 // 32-bit lanes per line
	localparam int LANE_W = 32;
	localparam int LINE_W = LANES * LANE_W;   // 256
	localparam int MEM_ADDR_W = 27;           // Core byte-line address

	//////////////////////////////////////////////////////////////////////
	// Sideband widths
	//////////////////////////////////////////////////////////////////////

	localparam int WARP_W = 3;
	localparam int SCB_W = 2;
	localparam int REG_W = 5;
	localparam int OFFSET_W = 24;
	localparam int LAT_W = 5;                 // Miss latency in cycles

	//////////////////////////////////////////////////////////////////////
	// State encodings
	//////////////////////////////////////////////////////////////////////

	// Host load handshake
	typedef enum logic [1:0]
	{
		FIO_IDLE  = 2'd0,
		FIO_WRITE = 2'd1,  // One-cycle line write
		FIO_ACK   = 2'd2   // Hold ack until req drops
	} fio_state_e;

	// One MSHR entry
	typedef enum logic [1:0]
	{
		MSHR_FREE = 2'd0,
		MSHR_WAIT = 2'd1,  // Latency counting down
		MSHR_DONE = 2'd2   // Waiting for its feedback slot
	} mshr_state_e;

endpackage

/* bram_bank.sv */
module bram_bank
	import gpu_mem_pkg::*;
#(
	parameter int MEM_WORDS = 512,
	localparam int AW = $clog2(MEM_WORDS)
)
(
	input  logic              clk,

	// Port A, read only
	input  logic [AW-1:0]     rd_addr_i,
	output logic [LANE_W-1:0] rd_data_o,

	// Port B, write only
	input  logic              wr_en_i,
	input  logic [AW-1:0]     wr_addr_i,
	input  logic [LANE_W-1:0] wr_data_i
);

	logic [LANE_W-1:0] mem [MEM_WORDS];

	// Registered read, old data on a same-address collision
	always_ff @(posedge clk)
	begin
		rd_data_o <= mem[rd_addr_i];
	end

	always_ff @(posedge clk)
	begin
		if (wr_en_i)
		begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

endmodule

/* mshr_table.sv */
module mshr_table
	import gpu_mem_pkg::*;
#(
	parameter int MSHR_DEPTH = 4
)
(
	input  logic                  clk,
	input  logic                  resetb,

	// Miss allocation
	input  logic                  alloc_i,
	input  logic [MEM_ADDR_W-1:0] addr_i,
	input  logic [WARP_W-1:0]     warp_id_i,
	input  logic [SCB_W-1:0]      scb_id_i,
	input  logic [LAT_W-1:0]      latency_i,
	output logic                  full_o,

	// Negative feedback
	output logic                  fb_valid_o,
	output logic [MEM_ADDR_W-1:0] fb_addr_o,
	output logic [WARP_W-1:0]     fb_warp_id_o,
	output logic [SCB_W-1:0]      fb_scb_id_o
);

	localparam int IDX_W = (MSHR_DEPTH > 1) ? $clog2(MSHR_DEPTH) : 1;

	mshr_state_e           state_q [MSHR_DEPTH];
	logic [LAT_W-1:0]      cnt_q   [MSHR_DEPTH];
	logic [MEM_ADDR_W-1:0] addr_q  [MSHR_DEPTH];
	logic [WARP_W-1:0]     warp_q  [MSHR_DEPTH];
	logic [SCB_W-1:0]      scb_q   [MSHR_DEPTH];

	logic             free_found;
	logic [IDX_W-1:0] free_idx;
	logic             done_found;
	logic [IDX_W-1:0] done_idx;
	logic             alloc_ok;

	//////////////////////////////////////////////////////////////////////
	// Priority picks, lowest index wins
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		free_found = 1'b0;
		free_idx = '0;
		done_found = 1'b0;
		done_idx = '0;
		for (int i = MSHR_DEPTH - 1; i >= 0; i--)
		begin
			if (state_q[i] == MSHR_FREE)
			begin
				free_found = 1'b1;
				free_idx = IDX_W'(i);
			end
			if (state_q[i] == MSHR_DONE)
			begin
				done_found = 1'b1;
				done_idx = IDX_W'(i);
			end
		end
	end

	assign full_o = !free_found;
	assign alloc_ok = alloc_i && free_found;   // Miss dropped when full

	//////////////////////////////////////////////////////////////////////
	// Entry state and latency counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			for (int i = 0; i < MSHR_DEPTH; i++)
			begin
				state_q[i] <= MSHR_FREE;
				cnt_q[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < MSHR_DEPTH; i++)
			begin
				case (state_q[i])
					MSHR_FREE:
					begin
						if (alloc_ok && free_idx == IDX_W'(i))
						begin
							state_q[i] <= MSHR_WAIT;
							cnt_q[i] <= latency_i;
						end
					end
					MSHR_WAIT:
					begin
						if (cnt_q[i] <= LAT_W'(1))
							state_q[i] <= MSHR_DONE;   // Pulse goes out on the next edge
						else
							cnt_q[i] <= cnt_q[i] - 1'b1;
					end
					MSHR_DONE:
					begin
						if (done_idx == IDX_W'(i))
							state_q[i] <= MSHR_FREE;
					end
					default: state_q[i] <= MSHR_FREE;
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (alloc_ok)
		begin
			addr_q[free_idx] <= addr_i;
			warp_q[free_idx] <= warp_id_i;
			scb_q[free_idx] <= scb_id_i;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Feedback output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
			fb_valid_o <= 1'b0;
		else
			fb_valid_o <= done_found;
	end

	always_ff @(posedge clk)
	begin
		if (done_found)
		begin
			fb_addr_o <= addr_q[done_idx];
			fb_warp_id_o <= warp_q[done_idx];
			fb_scb_id_o <= scb_q[done_idx];
		end
	end

endmodule

/* fio_loader.sv */
module fio_loader
	import gpu_mem_pkg::*;
#(
	parameter int MEM_WORDS = 512,
	localparam int AW = $clog2(MEM_WORDS)
)
(
	input  logic              clk,
	input  logic              resetb,

	// Host side, four-phase req/ack
	input  logic              fio_req_i,
	input  logic [AW-1:0]     fio_addr_i,
	input  logic [LINE_W-1:0] fio_data_i,
	output logic              fio_ack_o,

	// Memory side
	output logic              load_we_o,
	output logic [AW-1:0]     load_addr_o,
	output logic [LINE_W-1:0] load_data_o
);

	fio_state_e        state_q;
	fio_state_e        state_d;
	logic [AW-1:0]     addr_q;
	logic [LINE_W-1:0] data_q;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			FIO_IDLE:  if (fio_req_i) state_d = FIO_WRITE;
			FIO_WRITE: state_d = FIO_ACK;              // Exactly one write
			FIO_ACK:   if (!fio_req_i) state_d = FIO_IDLE;
			default:   state_d = FIO_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
			state_q <= FIO_IDLE;
		else
			state_q <= state_d;
	end

	// Host holds address and data stable while req is up
	always_ff @(posedge clk)
	begin
		if (state_q == FIO_IDLE && fio_req_i)
		begin
			addr_q <= fio_addr_i;
			data_q <= fio_data_i;
		end
	end

	assign load_we_o = (state_q == FIO_WRITE);
	assign load_addr_o = addr_q;
	assign load_data_o = data_q;
	assign fio_ack_o = (state_q == FIO_ACK);

endmodule

/* mem_stage.sv */
module mem_stage
	import gpu_mem_pkg::*;
#(
	parameter int MEM_WORDS = 512,
	parameter int MSHR_DEPTH = 4,
	localparam int AW = $clog2(MEM_WORDS)
)
(
	input  logic                  clk,
	input  logic                  resetb,

	// Core request
	input  logic                  mem_read_i,
	input  logic                  mem_write_i,
	input  logic [MEM_ADDR_W-1:0] mem_addr_i,
	input  logic [LINE_W-1:0]     write_data_i,
	input  logic [LANES-1:0]      write_mask_i,
	input  logic [WARP_W-1:0]     warp_id_i,
	input  logic [SCB_W-1:0]      scb_id_i,
	input  logic [REG_W-1:0]      reg_addr_i,
	input  logic [LANES-1:0]      thread_mask_i,
	input  logic [OFFSET_W-1:0]   word_offset_i,

	// Miss report from the tag stage
	input  logic                  addr_valid_i,
	input  logic                  hit_i,
	input  logic                  miss_wait_i,
	input  logic [LAT_W-1:0]      miss_latency_i,

	// Host load writes
	input  logic                  load_we_i,
	input  logic [AW-1:0]         load_addr_i,
	input  logic [LINE_W-1:0]     load_data_i,

	// Writeback
	output logic                  reg_write_o,
	output logic                  write_fb_valid_o,
	output logic [LINE_W-1:0]     read_data_o,
	output logic [WARP_W-1:0]     warp_id_o,
	output logic [SCB_W-1:0]      scb_id_o,
	output logic [REG_W-1:0]      reg_addr_o,
	output logic [LANES-1:0]      thread_mask_o,
	output logic [OFFSET_W-1:0]   word_offset_o,

	// Negative feedback
	output logic                  mshr_fb_valid_o,
	output logic [MEM_ADDR_W-1:0] mshr_fb_addr_o,
	output logic [WARP_W-1:0]     mshr_fb_warp_id_o,
	output logic [SCB_W-1:0]      mshr_fb_scb_id_o,
	output logic                  mshr_full_o
);

	logic [LINE_W-1:0]   rd_line;
	logic [LINE_W-1:0]   wr_line;
	logic [AW-1:0]       wr_addr;
	logic [LANES-1:0]    lane_we;
	logic [LAT_W-1:0]    latency;

	logic                read_r;
	logic                write_r;
	logic [WARP_W-1:0]   warp_r;
	logic [SCB_W-1:0]    scb_r;
	logic [REG_W-1:0]    reg_addr_r;
	logic [LANES-1:0]    thread_mask_r;
	logic [OFFSET_W-1:0] word_offset_r;

	//////////////////////////////////////////////////////////////////////
	// Data banks
	//////////////////////////////////////////////////////////////////////

	// Load side owns port B while its strobe is up
	assign wr_line = load_we_i ? load_data_i : write_data_i;
	assign wr_addr = load_we_i ? load_addr_i : mem_addr_i[AW-1:0];

	for (genvar g = 0; g < LANES; g++)
	begin : g_lane
		assign lane_we[g] = (mem_write_i && write_mask_i[g]) || load_we_i;

		bram_bank #(
			.MEM_WORDS (MEM_WORDS)
		) u_bank (
			.clk       (clk),
			.rd_addr_i (mem_addr_i[AW-1:0]),
			.rd_data_o (rd_line[g*LANE_W +: LANE_W]),
			.wr_en_i   (lane_we[g]),
			.wr_addr_i (wr_addr),
			.wr_data_i (wr_line[g*LANE_W +: LANE_W])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Sideband pipeline
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			read_r <= 1'b0;
			write_r <= 1'b0;
			reg_write_o <= 1'b0;
			write_fb_valid_o <= 1'b0;
		end
		else
		begin
			read_r <= mem_read_i;
			write_r <= mem_write_i;
			reg_write_o <= read_r;
			write_fb_valid_o <= write_r;
		end
	end

	always_ff @(posedge clk)
	begin
		warp_r <= warp_id_i;           // Input stage
		scb_r <= scb_id_i;
		reg_addr_r <= reg_addr_i;
		thread_mask_r <= thread_mask_i;
		word_offset_r <= word_offset_i;

		warp_id_o <= warp_r;           // Output stage
		scb_id_o <= scb_r;
		reg_addr_o <= reg_addr_r;
		thread_mask_o <= thread_mask_r;
		word_offset_o <= word_offset_r;

		if (read_r)
			read_data_o <= rd_line;    // Bank output valid one cycle after the read
	end

	//////////////////////////////////////////////////////////////////////
	// Miss tracking
	//////////////////////////////////////////////////////////////////////

	assign latency = miss_wait_i ? LAT_W'(1) : miss_latency_i;

	mshr_table #(
		.MSHR_DEPTH (MSHR_DEPTH)
	) u_mshr (
		.clk          (clk),
		.resetb       (resetb),
		.alloc_i      (addr_valid_i && !hit_i),
		.addr_i       (mem_addr_i),
		.warp_id_i    (warp_id_i),
		.scb_id_i     (scb_id_i),
		.latency_i    (latency),
		.full_o       (mshr_full_o),
		.fb_valid_o   (mshr_fb_valid_o),
		.fb_addr_o    (mshr_fb_addr_o),
		.fb_warp_id_o (mshr_fb_warp_id_o),
		.fb_scb_id_o  (mshr_fb_scb_id_o)
	);

endmodule

/* gpu_mem_top.sv */
module gpu_mem_top
	import gpu_mem_pkg::*;
#(
	parameter int MEM_WORDS = 512,
	parameter int MSHR_DEPTH = 4,
	localparam int AW = $clog2(MEM_WORDS)
)
(
	input  logic                  clk,
	input  logic                  resetb,

	// Core request
	input  logic                  mem_read_i,
	input  logic                  mem_write_i,
	input  logic [MEM_ADDR_W-1:0] mem_addr_i,
	input  logic [LINE_W-1:0]     write_data_i,
	input  logic [LANES-1:0]      write_mask_i,
	input  logic [WARP_W-1:0]     warp_id_i,
	input  logic [SCB_W-1:0]      scb_id_i,
	input  logic [REG_W-1:0]      reg_addr_i,
	input  logic [LANES-1:0]      thread_mask_i,
	input  logic [OFFSET_W-1:0]   word_offset_i,

	// Miss report
	input  logic                  addr_valid_i,
	input  logic                  hit_i,
	input  logic                  miss_wait_i,
	input  logic [LAT_W-1:0]      miss_latency_i,

	// Host load port
	input  logic                  fio_req_i,
	input  logic [AW-1:0]         fio_addr_i,
	input  logic [LINE_W-1:0]     fio_data_i,
	output logic                  fio_ack_o,

	// Writeback and feedback
	output logic                  reg_write_o,
	output logic                  write_fb_valid_o,
	output logic [LINE_W-1:0]     read_data_o,
	output logic [WARP_W-1:0]     warp_id_o,
	output logic [SCB_W-1:0]      scb_id_o,
	output logic [REG_W-1:0]      reg_addr_o,
	output logic [LANES-1:0]      thread_mask_o,
	output logic [OFFSET_W-1:0]   word_offset_o,
	output logic                  mshr_fb_valid_o,
	output logic [MEM_ADDR_W-1:0] mshr_fb_addr_o,
	output logic [WARP_W-1:0]     mshr_fb_warp_id_o,
	output logic [SCB_W-1:0]      mshr_fb_scb_id_o,
	output logic                  mshr_full_o
);

	logic              load_we;
	logic [AW-1:0]     load_addr;
	logic [LINE_W-1:0] load_data;

	fio_loader #(
		.MEM_WORDS (MEM_WORDS)
	) u_fio (
		.clk         (clk),
		.resetb      (resetb),
		.fio_req_i   (fio_req_i),
		.fio_addr_i  (fio_addr_i),
		.fio_data_i  (fio_data_i),
		.fio_ack_o   (fio_ack_o),
		.load_we_o   (load_we),
		.load_addr_o (load_addr),
		.load_data_o (load_data)
	);

	mem_stage #(
		.MEM_WORDS  (MEM_WORDS),
		.MSHR_DEPTH (MSHR_DEPTH)
	) u_mem (
		.clk               (clk),
		.resetb            (resetb),
		.mem_read_i        (mem_read_i),
		.mem_write_i       (mem_write_i),
		.mem_addr_i        (mem_addr_i),
		.write_data_i      (write_data_i),
		.write_mask_i      (write_mask_i),
		.warp_id_i         (warp_id_i),
		.scb_id_i          (scb_id_i),
		.reg_addr_i        (reg_addr_i),
		.thread_mask_i     (thread_mask_i),
		.word_offset_i     (word_offset_i),
		.addr_valid_i      (addr_valid_i),
		.hit_i             (hit_i),
		.miss_wait_i       (miss_wait_i),
		.miss_latency_i    (miss_latency_i),
		.load_we_i         (load_we),
		.load_addr_i       (load_addr),
		.load_data_i       (load_data),
		.reg_write_o       (reg_write_o),
		.write_fb_valid_o  (write_fb_valid_o),
		.read_data_o       (read_data_o),
		.warp_id_o         (warp_id_o),
		.scb_id_o          (scb_id_o),
		.reg_addr_o        (reg_addr_o),
		.thread_mask_o     (thread_mask_o),
		.word_offset_o     (word_offset_o),
		.mshr_fb_valid_o   (mshr_fb_valid_o),
		.mshr_fb_addr_o    (mshr_fb_addr_o),
		.mshr_fb_warp_id_o (mshr_fb_warp_id_o),
		.mshr_fb_scb_id_o  (mshr_fb_scb_id_o),
		.mshr_full_o       (mshr_full_o)
	);

endmodule

/* gpu_mem_properties.sv */
module gpu_mem_properties
	import gpu_mem_pkg::*;
#(
	parameter int MEM_WORDS = 512,
	parameter int MSHR_DEPTH = 4,
	localparam int AW = $clog2(MEM_WORDS),
	localparam int SB_W = WARP_W + SCB_W + REG_W + LANES + OFFSET_W
)
(
	input logic                  clk,
	input logic                  resetb,
	input logic                  mem_read_i,
	input logic                  mem_write_i,
	input logic [MEM_ADDR_W-1:0] mem_addr_i,
	input logic [LINE_W-1:0]     write_data_i,
	input logic [LANES-1:0]      write_mask_i,
	input logic [WARP_W-1:0]     warp_id_i,
	input logic [SCB_W-1:0]      scb_id_i,
	input logic [REG_W-1:0]      reg_addr_i,
	input logic [LANES-1:0]      thread_mask_i,
	input logic [OFFSET_W-1:0]   word_offset_i,
	input logic                  addr_valid_i,
	input logic                  hit_i,
	input logic                  miss_wait_i,
	input logic [LAT_W-1:0]      miss_latency_i,
	input logic                  fio_req_i,
	input logic                  fio_ack_o,
	input logic                  load_we,
	input logic [AW-1:0]         load_addr,
	input logic [LINE_W-1:0]     load_data,
	input logic                  reg_write_o,
	input logic                  write_fb_valid_o,
	input logic [LINE_W-1:0]     read_data_o,
	input logic [WARP_W-1:0]     warp_id_o,
	input logic [SCB_W-1:0]      scb_id_o,
	input logic [REG_W-1:0]      reg_addr_o,
	input logic [LANES-1:0]      thread_mask_o,
	input logic [OFFSET_W-1:0]   word_offset_o,
	input logic                  mshr_fb_valid_o,
	input logic [MEM_ADDR_W-1:0] mshr_fb_addr_o,
	input logic [WARP_W-1:0]     mshr_fb_warp_id_o,
	input logic [SCB_W-1:0]      mshr_fb_scb_id_o,
	input logic                  mshr_full_o
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int IDS = 2 ** WARP_W;

	logic [LINE_W-1:0]     shadow [MEM_WORDS];
	logic [LINE_W-1:0]     rd_exp;
	logic [LINE_W-1:0]     rd_exp_q1;
	logic [LINE_W-1:0]     rd_exp_q2;
	logic [SB_W-1:0]       sb_in;
	logic [SB_W-1:0]       sb_out;
	logic [SB_W-1:0]       sb_q1;
	logic [SB_W-1:0]       sb_q2;
	logic                  accept;
	logic [LAT_W-1:0]      eff_lat;
	logic                  exp_valid [IDS];
	logic                  exp_solo  [IDS];
	logic [MEM_ADDR_W-1:0] exp_addr  [IDS];
	logic [SCB_W-1:0]      exp_scb   [IDS];
	int                    exp_due   [IDS];
	logic                  solo_due_now;
	int                    cyc;
	int                    pending;
	int                    occupied;
	int                    fail_cnt = 0;

	//////////////////////////////////////////////////////////////////////
	// Shadow memory and read expectation
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (load_we)
			shadow[load_addr] <= load_data;    // Full line, wins port B
		else if (mem_write_i)
			for (int l = 0; l < LANES; l++)
				if (write_mask_i[l])
					shadow[mem_addr_i[AW-1:0]][l*LANE_W +: LANE_W] <=
						write_data_i[l*LANE_W +: LANE_W];
		rd_exp_q1 <= rd_exp;
		rd_exp_q2 <= rd_exp_q1;
		sb_q1 <= sb_in;
		sb_q2 <= sb_q1;
	end

	assign rd_exp = shadow[mem_addr_i[AW-1:0]];
	assign sb_in = {warp_id_i, scb_id_i, reg_addr_i, thread_mask_i, word_offset_i};
	assign sb_out = {warp_id_o, scb_id_o, reg_addr_o, thread_mask_o, word_offset_o};

	//////////////////////////////////////////////////////////////////////
	// Expected miss feedback, one record per warp id
	//////////////////////////////////////////////////////////////////////

	assign accept = addr_valid_i && !hit_i && !mshr_full_o;
	assign eff_lat = miss_wait_i ? LAT_W'(1) : miss_latency_i;
	assign occupied = pending - int'(mshr_fb_valid_o);   // Entry frees as its pulse rises

	always_comb
	begin
		solo_due_now = 1'b0;
		for (int w = 0; w < IDS; w++)
			if (exp_valid[w] && exp_solo[w] && cyc == exp_due[w])
				solo_due_now = 1'b1;
	end

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			cyc <= 0;
			pending <= 0;
			for (int w = 0; w < IDS; w++)
				exp_valid[w] <= 1'b0;
		end
		else
		begin
			cyc <= cyc + 1;
			pending <= pending + int'(accept) - int'(mshr_fb_valid_o);
			if (mshr_fb_valid_o)
				exp_valid[mshr_fb_warp_id_o] <= 1'b0;
			if (accept && pending != 0)
				for (int w = 0; w < IDS; w++)
					exp_solo[w] <= 1'b0;         // Sharing the table, timing not fixed
			if (accept)
			begin
				exp_valid[warp_id_i] <= 1'b1;
				exp_solo[warp_id_i] <= (pending == 0);
				exp_addr[warp_id_i] <= mem_addr_i;
				exp_scb[warp_id_i] <= scb_id_i;
				exp_due[warp_id_i] <= cyc + int'(eff_lat) + 2;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Properties
	//////////////////////////////////////////////////////////////////////

	a_reset_quiet: assert property (@(posedge clk) !resetb |-> !(reg_write_o ||
		write_fb_valid_o || mshr_fb_valid_o || mshr_full_o || fio_ack_o))
		else begin
			fail_cnt++;
			$error("Output strobe high during reset");
		end

	a_read_pipe: assert property (@(posedge clk) disable iff (!resetb)
		reg_write_o == $past(mem_read_i, 2))
		else begin
			fail_cnt++;
			$error("Fail reg_write_o got %h exp %h", $sampled(reg_write_o),
				!$sampled(reg_write_o));
		end

	a_write_pipe: assert property (@(posedge clk) disable iff (!resetb)
		write_fb_valid_o == $past(mem_write_i, 2))
		else begin
			fail_cnt++;
			$error("Fail write_fb_valid_o got %h exp %h", $sampled(write_fb_valid_o),
				!$sampled(write_fb_valid_o));
		end

	a_sideband: assert property (@(posedge clk) disable iff (!resetb)
		(mem_read_i || mem_write_i) |-> ##2 sb_out == sb_q2)
		else begin
			fail_cnt++;
			$error("Fail sb_out got %h exp %h", $sampled(sb_out), $sampled(sb_q2));
		end

	a_read_data: assert property (@(posedge clk) disable iff (!resetb)
		reg_write_o |-> read_data_o == rd_exp_q2)
		else begin
			fail_cnt++;
			$error("Fail read_data_o got %h exp %h", $sampled(read_data_o),
				$sampled(rd_exp_q2));
		end

	a_ack_rise: assert property (@(posedge clk) disable iff (!resetb)
		$rose(fio_ack_o) |-> fio_req_i)
		else begin
			fail_cnt++;
			$error("Ack rose without a request");
		end

	a_ack_fall: assert property (@(posedge clk) disable iff (!resetb)
		$fell(fio_ack_o) |-> !$past(fio_req_i))
		else begin
			fail_cnt++;
			$error("Ack fell while the request was still high");
		end

	a_one_load: assert property (@(posedge clk) disable iff (!resetb)
		$rose(fio_req_i) |-> ##1 load_we ##1 (!load_we && fio_ack_o))
		else begin
			fail_cnt++;
			$error("Handshake did not give exactly one load write");
		end

	a_fb_known: assert property (@(posedge clk) disable iff (!resetb)
		mshr_fb_valid_o |-> exp_valid[mshr_fb_warp_id_o])
		else begin
			fail_cnt++;
			$error("Miss feedback for a warp with no miss outstanding");
		end

	a_fb_addr: assert property (@(posedge clk) disable iff (!resetb)
		mshr_fb_valid_o |-> mshr_fb_addr_o == exp_addr[mshr_fb_warp_id_o])
		else begin
			fail_cnt++;
			$error("Fail mshr_fb_addr_o got %h exp %h", $sampled(mshr_fb_addr_o),
				exp_addr[$sampled(mshr_fb_warp_id_o)]);
		end

	a_fb_scb: assert property (@(posedge clk) disable iff (!resetb)
		mshr_fb_valid_o |-> mshr_fb_scb_id_o == exp_scb[mshr_fb_warp_id_o])
		else begin
			fail_cnt++;
			$error("Fail mshr_fb_scb_id_o got %h exp %h", $sampled(mshr_fb_scb_id_o),
				exp_scb[$sampled(mshr_fb_warp_id_o)]);
		end

	a_fb_time: assert property (@(posedge clk) disable iff (!resetb)
		solo_due_now == (mshr_fb_valid_o && exp_solo[mshr_fb_warp_id_o]))
		else begin
			fail_cnt++;
			$error("Miss feedback not at its latency");
		end

	a_unique_id: assert property (@(posedge clk) disable iff (!resetb)
		accept |-> !exp_valid[warp_id_i])
		else begin
			fail_cnt++;
			$error("Miss accepted for a warp already waiting");
		end

	a_full: assert property (@(posedge clk) disable iff (!resetb)
		mshr_full_o == (occupied == MSHR_DEPTH))
		else begin
			fail_cnt++;
			$error("Fail mshr_full_o got %h exp %h", $sampled(mshr_full_o),
				$sampled(occupied) == MSHR_DEPTH);
		end

endmodule

bind gpu_mem_top gpu_mem_properties #(
	.MEM_WORDS  (MEM_WORDS),
	.MSHR_DEPTH (MSHR_DEPTH)
) props_i (.*);

/* gpu_mem_tb.sv */
module gpu_mem_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import gpu_mem_pkg::*;

	localparam int MEM_WORDS = 512;
	localparam int MSHR_DEPTH = 4;
	localparam int AW = $clog2(MEM_WORDS);

	logic clk = 1'b0;
	logic resetb;
	logic mem_read_i, mem_write_i;
	logic [MEM_ADDR_W-1:0] mem_addr_i;
	logic [LINE_W-1:0] write_data_i;
	logic [LANES-1:0] write_mask_i, thread_mask_i;
	logic [WARP_W-1:0] warp_id_i;
	logic [SCB_W-1:0] scb_id_i;
	logic [REG_W-1:0] reg_addr_i;
	logic [OFFSET_W-1:0] word_offset_i;
	logic addr_valid_i, hit_i, miss_wait_i;
	logic [LAT_W-1:0] miss_latency_i;
	logic fio_req_i;
	logic [AW-1:0] fio_addr_i;
	logic [LINE_W-1:0] fio_data_i;
	logic fio_ack_o, reg_write_o, write_fb_valid_o, mshr_fb_valid_o, mshr_full_o;
	logic [LINE_W-1:0] read_data_o;
	logic [WARP_W-1:0] warp_id_o, mshr_fb_warp_id_o;
	logic [SCB_W-1:0] scb_id_o, mshr_fb_scb_id_o;
	logic [REG_W-1:0] reg_addr_o;
	logic [LANES-1:0] thread_mask_o;
	logic [OFFSET_W-1:0] word_offset_o;
	logic [MEM_ADDR_W-1:0] mshr_fb_addr_o;

	int timeouts = 0;
	int errors;
	logic [AW-1:0] lines [$];

	gpu_mem_top #(
		.MEM_WORDS  (MEM_WORDS),
		.MSHR_DEPTH (MSHR_DEPTH)
	) dut_i (.*);

	always #2 clk = !clk;

	function automatic logic [LINE_W-1:0] rand_line();
		logic [LINE_W-1:0] v;
		for (int l = 0; l < LANES; l++)
			v[l*LANE_W +: LANE_W] = $urandom;
		return v;
	endfunction

	task automatic drive_sidebands(input logic [AW-1:0] line);
		mem_addr_i <= {(MEM_ADDR_W-AW)'($urandom), line};   // Upper bits are don't-care
		warp_id_i <= WARP_W'($urandom);
		scb_id_i <= SCB_W'($urandom);
		reg_addr_i <= REG_W'($urandom);
		thread_mask_i <= LANES'($urandom);
		word_offset_i <= OFFSET_W'($urandom);
	endtask

	task automatic host_load(input logic [AW-1:0] addr, input logic [LINE_W-1:0] data);
		int n;
		@(posedge clk);
		fio_req_i <= 1'b1;
		fio_addr_i <= addr;
		fio_data_i <= data;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end while (!fio_ack_o && n < 20);
		if (!fio_ack_o)
		begin
			timeouts++;
			$display("Timeout waiting for fio_ack_o to rise");
		end
		@(posedge clk);
		fio_req_i <= 1'b0;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end while (fio_ack_o && n < 20);
		if (fio_ack_o)
		begin
			timeouts++;
			$display("Timeout waiting for fio_ack_o to fall");
		end
	endtask

	// Masked store, then a read of the same line in the next cycle
	task automatic write_read(input logic [AW-1:0] line);
		@(posedge clk);
		mem_write_i <= 1'b1;
		write_data_i <= rand_line();
		write_mask_i <= LANES'($urandom);
		drive_sidebands(line);
		@(posedge clk);
		mem_write_i <= 1'b0;
		mem_read_i <= 1'b1;
		drive_sidebands(line);
		@(posedge clk);
		mem_read_i <= 1'b0;
	endtask

	task automatic issue_miss(input int warp, input int lat, input logic wait_b,
		input logic hit);
		@(posedge clk);
		addr_valid_i <= 1'b1;
		hit_i <= hit;
		miss_wait_i <= wait_b;
		miss_latency_i <= LAT_W'(lat);
		drive_sidebands(AW'($urandom));
		warp_id_i <= WARP_W'(warp);
	endtask

	task automatic wait_mshr_drain();
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end while (dut_i.props_i.pending != 0 && n < 200);
		if (dut_i.props_i.pending != 0)
		begin
			timeouts++;
			$display("Timeout waiting for miss feedback");
		end
	endtask

	initial
	begin
		void'($urandom(32'h904d_fd3b));
		resetb = 1'b0;
		{mem_read_i, mem_write_i, addr_valid_i, hit_i, miss_wait_i, fio_req_i} = '0;
		mem_addr_i = '0;
		write_data_i = '0;
		write_mask_i = '0;
		{warp_id_i, scb_id_i, reg_addr_i, thread_mask_i, word_offset_i} = '0;
		miss_latency_i = '0;
		fio_addr_i = '0;
		fio_data_i = '0;
		repeat (2) @(posedge clk);
		resetb <= 1'b1;
		repeat (3) @(posedge clk);

		//////////////////////////////////////////////////////////////////////
		// Host loads, stores and reads
		//////////////////////////////////////////////////////////////////////

		for (int i = 0; i < 8; i++)
		begin
			lines.push_back(AW'(i * 61 + 5));
			host_load(lines[i], rand_line());
		end
		for (int i = 0; i < 12; i++)
			write_read(lines[$urandom % lines.size()]);
		for (int i = 0; i < 20; i++)
		begin
			@(posedge clk);
			mem_read_i <= 1'b1;
			drive_sidebands(lines[$urandom % lines.size()]);
		end
		@(posedge clk);
		mem_read_i <= 1'b0;
		repeat (3) @(posedge clk);

		//////////////////////////////////////////////////////////////////////
		// Misses, single then beyond depth
		//////////////////////////////////////////////////////////////////////

		for (int i = 0; i < 8; i++)
		begin
			issue_miss(i, 1 + $urandom % 20, 1'($urandom), i == 3);   // One hit
			@(posedge clk);
			addr_valid_i <= 1'b0;
			wait_mshr_drain();
		end
		for (int i = 0; i <= MSHR_DEPTH; i++)
			issue_miss(i, 20, 1'b0, 1'b0);     // Last one finds the table full
		@(posedge clk);
		addr_valid_i <= 1'b0;
		wait_mshr_drain();
		repeat (5) @(posedge clk);

		errors = dut_i.props_i.fail_cnt + timeouts;
		$display("Assertion errors: %0d, timeouts: %0d", dut_i.props_i.fail_cnt, timeouts);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* filelist.f */
gpu_mem_pkg.sv
bram_bank.sv
mshr_table.sv
fio_loader.sv
mem_stage.sv
gpu_mem_top.sv
gpu_mem_properties.sv
gpu_mem_tb.sv
